// File: source/datapath_pkg.sv
package datapath_pkg;

	localparam int num_regs = 16;
	localparam int c_width = 15;

	// bus source numbers, 0 to 15 are the general registers.
	localparam logic [4:0] src_hi = 5'd16;
	localparam logic [4:0] src_lo = 5'd17;
	localparam logic [4:0] src_zhigh = 5'd18;
	localparam logic [4:0] src_zlow = 5'd19;
	localparam logic [4:0] src_inport = 5'd22; // 20 and 21 held pc and mdr.
	localparam logic [4:0] src_c = 5'd23;
	localparam logic [4:0] src_none = 5'd31;

	typedef logic [31:0] word_t;

	typedef enum logic [4:0] {
		op_ldi = 5'd0,
		op_add = 5'd1,
		op_sub = 5'd2,
		op_and = 5'd3,
		op_or = 5'd4,
		op_mul = 5'd5,
		op_mfhi = 5'd6,
		op_mflo = 5'd7,
		op_in = 5'd8,
		op_out = 5'd9
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or = 3'd3,
		alu_mul = 3'd4,
		alu_pass = 3'd5
	} alu_op_t;

	typedef enum logic [2:0] {
		s_idle = 3'd0,
		s_t1 = 3'd1,
		s_t2 = 3'd2,
		s_t3 = 3'd3,
		s_t4 = 3'd4
	} state_t;

	typedef struct packed {
		opcode_t opcode;
		logic [3:0] ra; // destination.
		logic [3:0] rb;
		logic [3:0] rc;
		logic [c_width-1:0] c;
	} instr_t;

	typedef struct packed {
		logic [num_regs-1:0] r_out;
		logic hi_out;
		logic lo_out;
		logic zhigh_out;
		logic zlow_out;
		logic inport_out;
		logic c_out;
	} bus_sel_t;

	typedef struct packed {
		logic [num_regs-1:0] r_in;
		logic hi_in;
		logic lo_in;
		logic hilo_from_z; // hi/lo load from z instead of the bus.
	} reg_ctrl_t;

	typedef struct packed {
		logic y_in;
		logic z_in;
		alu_op_t op;
	} alu_ctrl_t;

endpackage

// File: source/bus.sv
`timescale 1ns/100ps
module bus import datapath_pkg::*; (
	input bus_sel_t sel,
	input word_t r [num_regs],
	input word_t hi,
	input word_t lo,
	input word_t zhigh,
	input word_t zlow,
	input word_t inport_q,
	input word_t c_sext,
	output word_t bus_data
);

	logic [4:0] src; // encoded source number.

	// lowest numbered strobe wins.
	always_comb
	begin
		src = src_none;
		if (sel.r_out != '0)
		begin
			for (int i = num_regs - 1; i >= 0; i--)
				if (sel.r_out[i])
					src = 5'(i);
		end
		else if (sel.hi_out)
			src = src_hi;
		else if (sel.lo_out)
			src = src_lo;
		else if (sel.zhigh_out)
			src = src_zhigh;
		else if (sel.zlow_out)
			src = src_zlow;
		else if (sel.inport_out)
			src = src_inport;
		else if (sel.c_out)
			src = src_c;
	end

	always_comb
	begin
		case (src)
			src_hi: bus_data = hi;
			src_lo: bus_data = lo;
			src_zhigh: bus_data = zhigh;
			src_zlow: bus_data = zlow;
			src_inport: bus_data = inport_q;
			src_c: bus_data = c_sext;
			default: bus_data = (src < 5'(num_regs)) ? r[src[3:0]] : '0; // none reads zero.
		endcase
	end

endmodule

// File: source/register_file.sv
`timescale 1ns/100ps
module register_file import datapath_pkg::*; (
	input logic clock,
	input logic rst,
	input reg_ctrl_t regs,
	input word_t bus_data,
	input word_t zhigh,
	input word_t zlow,
	output word_t r [num_regs],
	output word_t hi,
	output word_t lo
);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < num_regs; i++)
				r[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < num_regs; i++)
				if (regs.r_in[i])
					r[i] <= bus_data;
		end
	end

	// hi/lo take the product halves straight from z during mul.
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			hi <= '0;
			lo <= '0;
		end
		else
		begin
			if (regs.hi_in)
				hi <= regs.hilo_from_z ? zhigh : bus_data;
			if (regs.lo_in)
				lo <= regs.hilo_from_z ? zlow : bus_data;
		end
	end

endmodule

// File: source/alu_unit.sv
`timescale 1ns/100ps
module alu_unit import datapath_pkg::*; (
	input logic clock,
	input logic rst,
	input alu_ctrl_t alu,
	input word_t bus_data,
	output word_t zhigh,
	output word_t zlow
);

	word_t y;
	word_t res32;
	logic [63:0] result;

	always_ff @(posedge clock)
	begin
		if (rst)
			y <= '0;
		else if (alu.y_in)
			y <= bus_data;
	end

	// y is the first operand, the bus the second.
	always_comb
	begin
		case (alu.op)
			alu_add: res32 = y + bus_data;
			alu_sub: res32 = y - bus_data;
			alu_and: res32 = y & bus_data;
			alu_or: res32 = y | bus_data;
			alu_pass: res32 = bus_data;
			default: res32 = '0;
		endcase
	end

	always_comb
	begin
		if (alu.op == alu_mul)
		begin
			// low 64 bits of the sign extended operands give the signed product.
			result = {{32{y[31]}}, y} * {{32{bus_data[31]}}, bus_data};
		end
		else
			result = {{32{res32[31]}}, res32};
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			zhigh <= '0;
			zlow <= '0;
		end
		else if (alu.z_in)
		begin
			zhigh <= result[63:32];
			zlow <= result[31:0];
		end
	end

endmodule

// File: source/io_ports.sv
`timescale 1ns/100ps
module io_ports import datapath_pkg::*; (
	input logic clock,
	input logic rst,
	input word_t inport,
	input logic out_in,
	input word_t bus_data,
	output word_t inport_q,
	output word_t outport
);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			inport_q <= '0;
			outport <= '0;
		end
		else
		begin
			inport_q <= inport; // sampled every cycle.
			if (out_in)
				outport <= bus_data;
		end
	end

endmodule

// File: source/control_unit.sv
`timescale 1ns/100ps
module control_unit import datapath_pkg::*; (
	input logic clock,
	input logic rst,
	input instr_t instr,
	input logic instr_valid,
	output bus_sel_t sel,
	output reg_ctrl_t regs,
	output alu_ctrl_t alu,
	output logic out_in,
	output word_t c_sext,
	output logic busy,
	output logic done
);

	state_t state;
	state_t state_next;
	state_t last_step;
	instr_t ir; // latched instruction.
	logic is_alu;

	always_ff @(posedge clock)
	begin
		if (state == s_idle && instr_valid)
			ir <= instr;
	end

	assign c_sext = {{(32 - c_width){ir.c[c_width-1]}}, ir.c};
	assign is_alu = ir.opcode inside {op_add, op_sub, op_and, op_or, op_mul};

	always_comb
	begin
		case (ir.opcode)
			op_add, op_sub, op_and, op_or: last_step = s_t3;
			op_mul: last_step = s_t4;
			default: last_step = s_t1;
		endcase
	end

	assign busy = (state != s_idle);
	assign done = (state == last_step); // last_step is never s_idle.

	always_comb
	begin
		case (state)
			s_idle: state_next = instr_valid ? s_t1 : s_idle;
			s_t1: state_next = s_t2;
			s_t2: state_next = s_t3;
			s_t3: state_next = s_t4;
			default: state_next = s_idle;
		endcase
		if (done)
			state_next = s_idle;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			state <= s_idle;
		else
			state <= state_next;
	end

	// strobe decode from step and opcode.
	always_comb
	begin
		sel = '0;
		regs = '0;
		alu = '0;
		alu.op = alu_pass;
		out_in = 1'b0;
		case (state)
			s_t1:
				if (is_alu)
				begin
					sel.r_out[ir.rb] = 1'b1;
					alu.y_in = 1'b1;
				end
				else
				begin
					regs.r_in[ir.ra] = (ir.opcode != op_out);
					case (ir.opcode)
						op_ldi: sel.c_out = 1'b1;
						op_mfhi: sel.hi_out = 1'b1;
						op_mflo: sel.lo_out = 1'b1;
						op_in: sel.inport_out = 1'b1;
						op_out:
						begin
							sel.r_out[ir.rb] = 1'b1;
							out_in = 1'b1;
						end
						default: ;
					endcase
				end
			s_t2:
			begin
				sel.r_out[ir.rc] = 1'b1;
				alu.z_in = 1'b1;
				case (ir.opcode)
					op_add: alu.op = alu_add;
					op_sub: alu.op = alu_sub;
					op_and: alu.op = alu_and;
					op_or: alu.op = alu_or;
					op_mul: alu.op = alu_mul;
					default: alu.op = alu_pass;
				endcase
			end
			s_t3:
				if (ir.opcode == op_mul)
				begin
					regs.lo_in = 1'b1;
					regs.hilo_from_z = 1'b1;
				end
				else
				begin
					sel.zlow_out = 1'b1;
					regs.r_in[ir.ra] = 1'b1;
				end
			s_t4:
			begin
				regs.hi_in = 1'b1; // mul only.
				regs.hilo_from_z = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: source/cpu_top.sv
`timescale 1ns/100ps
module cpu_top import datapath_pkg::*; (
	input logic clock,
	input logic rst,
	input instr_t instr,
	input logic instr_valid,
	input word_t inport,
	output logic busy,
	output logic done,
	output word_t outport
);

	bus_sel_t sel;
	reg_ctrl_t regs;
	alu_ctrl_t alu;
	logic out_in;
	word_t c_sext;
	word_t bus_data;
	word_t r [num_regs];
	word_t hi;
	word_t lo;
	word_t zhigh;
	word_t zlow;
	word_t inport_q;

	control_unit u_control (
		.clock(clock),
		.rst(rst),
		.instr(instr),
		.instr_valid(instr_valid),
		.sel(sel),
		.regs(regs),
		.alu(alu),
		.out_in(out_in),
		.c_sext(c_sext),
		.busy(busy),
		.done(done)
	);

	bus u_bus (
		.sel(sel),
		.r(r),
		.hi(hi),
		.lo(lo),
		.zhigh(zhigh),
		.zlow(zlow),
		.inport_q(inport_q),
		.c_sext(c_sext),
		.bus_data(bus_data)
	);

	register_file u_regs (
		.clock(clock),
		.rst(rst),
		.regs(regs),
		.bus_data(bus_data),
		.zhigh(zhigh),
		.zlow(zlow),
		.r(r),
		.hi(hi),
		.lo(lo)
	);

	alu_unit u_alu (
		.clock(clock),
		.rst(rst),
		.alu(alu),
		.bus_data(bus_data),
		.zhigh(zhigh),
		.zlow(zlow)
	);

	io_ports u_io (
		.clock(clock),
		.rst(rst),
		.inport(inport),
		.out_in(out_in),
		.bus_data(bus_data),
		.inport_q(inport_q),
		.outport(outport)
	);

endmodule

// File: sim/cpu_assert.sv
`timescale 1ns/100ps
module cpu_assert import datapath_pkg::*; (
	input logic clock,
	input logic rst,
	input bus_sel_t sel,
	input logic busy,
	input logic done
);

	// one bus driver at a time.
	a_one_source: assert property (@(posedge clock) disable iff (rst) $onehot0(sel))
		else $error("more than one bus source strobe is high");

	a_done_in_busy: assert property (@(posedge clock) disable iff (rst) done |-> busy)
		else $error("done is high while busy is low");

	a_busy_falls: assert property (@(posedge clock) disable iff (rst) done |=> !busy)
		else $error("busy did not fall in the cycle after done");

endmodule

bind control_unit cpu_assert u_assert (
	.clock(clock),
	.rst(rst),
	.sel(sel),
	.busy(busy),
	.done(done)
);

// File: sim/tb_cpu.sv
`timescale 1ns/100ps
module tb_cpu import datapath_pkg::*; ();

	typedef struct packed {
		instr_t ins;
		word_t in_val; // inport value held while the entry runs.
	} entry_t;

	logic clock = 1'b0;
	logic rst;
	instr_t instr;
	logic instr_valid;
	word_t inport;
	logic busy;
	logic done;
	word_t outport;

	entry_t table_q [$];
	word_t m_r [num_regs]; // reference register file.
	word_t m_hi;
	word_t m_lo;
	integer seed = 32'h6aa2;
	logic table_ready = 1'b0;

	cpu_top uut (
		.clock(clock),
		.rst(rst),
		.instr(instr),
		.instr_valid(instr_valid),
		.inport(inport),
		.busy(busy),
		.done(done),
		.outport(outport)
	);

	always #20 clock = ~clock; // 40 ns period.

	function automatic instr_t encode(opcode_t op, logic [3:0] ra, logic [3:0] rb,
		logic [3:0] rc, logic [c_width-1:0] c);
		instr_t ins;
		ins.opcode = op;
		ins.ra = ra;
		ins.rb = rb;
		ins.rc = rc;
		ins.c = c;
		return ins;
	endfunction

	// steps from acceptance to done.
	function automatic int latency(opcode_t op);
		case (op)
			op_add, op_sub, op_and, op_or: return 3;
			op_mul: return 4;
			default: return 1;
		endcase
	endfunction

	task automatic check(input string name, input word_t got, input word_t expected);
		if (got !== expected)
		begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("Result: FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic add_entry(input instr_t ins, input word_t in_val);
		entry_t e;
		e.ins = ins;
		e.in_val = in_val;
		table_q.push_back(e);
	endtask

	task automatic add_out(input logic [3:0] rb);
		add_entry(encode(op_out, 4'd0, rb, 4'd0, '0), '0);
	endtask

	task automatic fill_table();
		add_entry(encode(op_ldi, 4'd1, 4'd0, 4'd0, 15'h7ffb), '0); // -5.
		add_out(4'd1);
		add_entry(encode(op_ldi, 4'd2, 4'd0, 4'd0, 15'h3fff), '0);
		add_out(4'd2);
		add_entry(encode(op_ldi, 4'd3, 4'd0, 4'd0, 15'h4000), '0); // most negative.
		add_out(4'd3);
		for (int i = 4; i < 10; i++)
			add_entry(encode(op_ldi, 4'(i), 4'd0, 4'd0, 15'($random(seed))), '0);
		for (int i = 10; i < 13; i++)
			add_entry(encode(op_in, 4'(i), 4'd0, 4'd0, '0), $random(seed));
		add_entry(encode(op_add, 4'd13, 4'd4, 4'd10, '0), '0);
		add_out(4'd13);
		add_entry(encode(op_sub, 4'd14, 4'd5, 4'd11, '0), '0);
		add_out(4'd14);
		add_entry(encode(op_and, 4'd15, 4'd10, 4'd11, '0), '0);
		add_out(4'd15);
		add_entry(encode(op_or, 4'd13, 4'd12, 4'd6, '0), '0);
		add_out(4'd13);
		add_entry(encode(op_add, 4'd4, 4'd4, 4'd10, '0), '0); // destination is also a source.
		add_out(4'd4);
		add_entry(encode(op_sub, 4'd5, 4'd11, 4'd11, '0), '0);
		add_out(4'd5);
		// carry out of bit 31 is lost.
		add_entry(encode(op_in, 4'd1, 4'd0, 4'd0, '0), 32'hffff_fff0);
		add_entry(encode(op_in, 4'd2, 4'd0, 4'd0, '0), 32'h0000_0025);
		add_entry(encode(op_add, 4'd3, 4'd1, 4'd2, '0), '0);
		add_out(4'd3);
		add_entry(encode(op_mul, 4'd0, 4'd10, 4'd11, '0), '0);
		add_entry(encode(op_mflo, 4'd6, 4'd0, 4'd0, '0), '0);
		add_entry(encode(op_mfhi, 4'd7, 4'd0, 4'd0, '0), '0);
		add_out(4'd6);
		add_out(4'd7);
		add_entry(encode(op_mul, 4'd0, 4'd3, 4'd1, '0), '0); // negative times positive.
		add_entry(encode(op_mfhi, 4'd8, 4'd0, 4'd0, '0), '0);
		add_entry(encode(op_mflo, 4'd9, 4'd0, 4'd0, '0), '0);
		add_out(4'd8);
		add_out(4'd9);
		add_entry(encode(op_in, 4'd0, 4'd0, 4'd0, '0), $random(seed));
		add_out(4'd0);
	endtask

	task automatic update_model(input instr_t ins, input word_t in_val);
		logic signed [63:0] prod;
		case (ins.opcode)
			op_ldi: m_r[ins.ra] = 32'($signed(ins.c));
			op_add: m_r[ins.ra] = m_r[ins.rb] + m_r[ins.rc];
			op_sub: m_r[ins.ra] = m_r[ins.rb] - m_r[ins.rc];
			op_and: m_r[ins.ra] = m_r[ins.rb] & m_r[ins.rc];
			op_or: m_r[ins.ra] = m_r[ins.rb] | m_r[ins.rc];
			op_mul:
			begin
				prod = longint'($signed(m_r[ins.rb])) * longint'($signed(m_r[ins.rc]));
				m_hi = prod[63:32];
				m_lo = prod[31:0];
			end
			op_mfhi: m_r[ins.ra] = m_hi;
			op_mflo: m_r[ins.ra] = m_lo;
			op_in: m_r[ins.ra] = in_val;
			default: ;
		endcase
	endtask

	// applies one instruction and counts the cycles until done.
	task automatic run_instr(input instr_t ins, input word_t in_val, input logic inject,
		output int cycles);
		logic seen;
		@(posedge clock);
		inport <= in_val; // steady one cycle ahead.
		@(posedge clock);
		instr <= ins;
		instr_valid <= 1'b1;
		@(posedge clock); // accepted here.
		instr_valid <= 1'b0;
		cycles = 0;
		seen = 1'b0;
		while (!seen)
		begin
			@(negedge clock);
			cycles++;
			check("busy", 32'(busy), 32'd1); // high in every step.
			seen = done;
			if (!seen)
			begin
				@(posedge clock);
				if (inject && cycles == 1)
				begin
					instr <= encode(op_ldi, ins.ra, 4'd0, 4'd0, 15'h2aaa); // must be ignored.
					instr_valid <= 1'b1;
				end
				else
					instr_valid <= 1'b0;
			end
		end
	endtask

	initial
	begin
		wait (table_ready);
		repeat (table_q.size() * 6 + 5 + 10) @(posedge clock);
		$display("timeout: done never came for the instruction in progress");
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		instr_t ins;
		word_t expect_out;
		int cycles;
		instr <= '0;
		instr_valid <= 1'b0;
		inport <= '0;
		rst <= 1'b1;
		for (int i = 0; i < num_regs; i++)
			m_r[i] = '0;
		m_hi = '0;
		m_lo = '0;
		fill_table();
		table_ready = 1'b1;
		repeat (5) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);
		@(negedge clock);
		check("outport", outport, '0);
		check("busy", 32'(busy), '0);
		for (int i = 0; i < table_q.size(); i++)
		begin
			ins = table_q[i].ins;
			expect_out = m_r[ins.rb];
			run_instr(ins, table_q[i].in_val, (i % 2 == 1) && (latency(ins.opcode) > 2),
				cycles);
			check("done latency", 32'(cycles), 32'(latency(ins.opcode)));
			update_model(ins, table_q[i].in_val);
			if (ins.opcode == op_out)
			begin
				@(posedge clock);
				@(negedge clock);
				check("outport", outport, expect_out);
			end
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: tb.f
source/datapath_pkg.sv
source/bus.sv
source/register_file.sv
source/alu_unit.sv
source/io_ports.sv
source/control_unit.sv
source/cpu_top.sv
sim/cpu_assert.sv
sim/tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

FAIL_MSG = Result: FAILED
PASS_MSG = Result: PASSED
SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
